/* design/p4_router_pkg.sv */
// p4 router shared definitions
// stream beat and metadata structs, widths, register map

package p4_router_pkg;

    ////////////////////
    // widths

    localparam int DATA_BYTES  = 8;                  // bytes per stream beat
    localparam int ING_PORT_W  = 4;                  // ingress port id
    localparam int EGR_SPEC_W  = 4;                  // egress spec
    localparam int REG_ADDR_W  = 6;                  // register word index
    localparam int MAP_ENTRIES = 1 << ING_PORT_W;    // one map slot per ingress port

    ////////////////////
    // typedefs

    typedef logic [ING_PORT_W-1:0] ing_port_t;
    typedef logic [EGR_SPEC_W-1:0] egr_spec_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [31:0]           reg_data_t;

    typedef struct packed {
        logic [DATA_BYTES*8-1:0] tdata;              // payload
        logic [DATA_BYTES-1:0]   tkeep;              // byte enables
        logic                    tlast;              // end of packet
    } beat_t;

    typedef struct packed {
        ing_port_t ing_port;
        egr_spec_t egr_spec;
    } meta_out_t;

    typedef struct packed {
        logic      valid;                            // entry programmed
        egr_spec_t egr_spec;
    } map_entry_t;

    typedef map_entry_t [MAP_ENTRIES-1:0] map_table_t;

    ////////////////////
    // register indices

    localparam reg_addr_t REG_DEFAULT_EGR = 6'd0;    // egress for unmapped ports
    localparam reg_addr_t REG_PKT_COUNT   = 6'd1;    // packets out, read only
    localparam reg_addr_t REG_STATUS      = 6'd2;    // bit 0 overflow, w1c
    localparam reg_addr_t REG_MAP_BASE    = 6'd16;   // map entry i at base + i
    localparam int        MAP_VALID_BIT   = 8;       // valid bit inside a map word

endpackage

/* design/p4_router_regs.sv */
// p4 router register block
// port map table, default egress, packet counter and sticky overflow flag

module p4_router_regs (
    input  var logic                      clk,
    input  var logic                      rst_n,
    input  var logic                      reg_wr,
    input  var logic                      reg_rd,
    input  var p4_router_pkg::reg_addr_t  reg_addr,
    input  var p4_router_pkg::reg_data_t  reg_wdata,
    input  var logic                      pkt_done,
    input  var logic                      overflow_pulse,
    output var p4_router_pkg::reg_data_t  reg_rdata,
    output var p4_router_pkg::map_table_t map_table,
    output var p4_router_pkg::egr_spec_t  default_egr,
    output var logic                      overflow_event
);

    p4_router_pkg::reg_data_t  pkt_count;           // wraps at 2^32
    logic                      map_hit;             // address falls in map window
    p4_router_pkg::ing_port_t  map_idx;             // entry under the address
    p4_router_pkg::reg_data_t  rd_mux;

    ////////////////////
    // address decode

    assign map_hit = (reg_addr >= p4_router_pkg::REG_MAP_BASE) &&
                     (reg_addr < p4_router_pkg::REG_MAP_BASE + p4_router_pkg::MAP_ENTRIES);
    assign map_idx = p4_router_pkg::ing_port_t'(reg_addr - p4_router_pkg::REG_MAP_BASE);

    ////////////////////
    // writes and counters

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            map_table      <= '0;                   // all entries invalid
            default_egr    <= '0;
            pkt_count      <= '0;
            overflow_event <= 1'b0;
        end else begin
            if (reg_wr && map_hit) begin
                map_table[map_idx].valid    <= reg_wdata[p4_router_pkg::MAP_VALID_BIT];
                map_table[map_idx].egr_spec <= reg_wdata[p4_router_pkg::EGR_SPEC_W-1:0];
            end
            if (reg_wr && reg_addr == p4_router_pkg::REG_DEFAULT_EGR)
                default_egr <= reg_wdata[p4_router_pkg::EGR_SPEC_W-1:0];
            if (pkt_done)
                pkt_count <= pkt_count + 1'b1;      // one per output last beat
            // a new overflow wins over a clear in the same cycle
            if (overflow_pulse)
                overflow_event <= 1'b1;
            else if (reg_wr && reg_addr == p4_router_pkg::REG_STATUS && reg_wdata[0])
                overflow_event <= 1'b0;             // write 1 to clear
        end
    end

    ////////////////////
    // read path

    always_comb begin
        rd_mux = '0;
        if (map_hit) begin
            rd_mux[p4_router_pkg::MAP_VALID_BIT]     = map_table[map_idx].valid;
            rd_mux[p4_router_pkg::EGR_SPEC_W-1:0]    = map_table[map_idx].egr_spec;
        end else if (reg_addr == p4_router_pkg::REG_DEFAULT_EGR) begin
            rd_mux[p4_router_pkg::EGR_SPEC_W-1:0]    = default_egr;
        end else if (reg_addr == p4_router_pkg::REG_PKT_COUNT) begin
            rd_mux = pkt_count;
        end else if (reg_addr == p4_router_pkg::REG_STATUS) begin
            rd_mux[0] = overflow_event;
        end
    end

    always_ff @(posedge clk) begin
        if (reg_rd)
            reg_rdata <= rd_mux;                    // valid the cycle after reg_rd
    end

    // host side must never issue both strobes at once
    assert property (@(posedge clk) disable iff (!rst_n) !(reg_wr && reg_rd));

endmodule

/* design/p4_router_lookup.sv */
// p4 router metadata lookup
// queue of ingress ports per packet, egress spec resolved through the port map

module p4_router_lookup #(
    parameter int META_DEPTH = 4
) (
    input  var logic                      clk,
    input  var logic                      rst_n,
    input  var p4_router_pkg::ing_port_t  meta_in_port,
    input  var logic                      meta_in_valid,
    input  var p4_router_pkg::map_table_t map_table,
    input  var p4_router_pkg::egr_spec_t  default_egr,
    input  var logic                      pkt_done,
    input  var logic                      first_beat,
    output var logic                      meta_avail,
    output var p4_router_pkg::meta_out_t  meta_head,
    output var logic                      overflow_pulse
);

    localparam int PTR_W = (META_DEPTH > 1) ? $clog2(META_DEPTH) : 1;
    localparam int CNT_W = $clog2(META_DEPTH + 1);

    p4_router_pkg::ing_port_t q_port [META_DEPTH];  // ingress port per packet
    p4_router_pkg::egr_spec_t q_spec [META_DEPTH];  // spec frozen at first beat
    logic [META_DEPTH-1:0]    q_frozen;             // q_spec holds the answer

    logic [PTR_W-1:0]         wr_ptr;
    logic [PTR_W-1:0]         rd_ptr;
    logic [CNT_W-1:0]         count;
    logic                     full;
    logic                     push;
    p4_router_pkg::map_entry_t head_entry;
    p4_router_pkg::egr_spec_t resolved;             // live map answer for head

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(META_DEPTH - 1)) ? '0 : p + 1'b1;  // wraps at any depth
    endfunction

    assign full           = (count == CNT_W'(META_DEPTH));
    assign push           = meta_in_valid && !full;
    assign overflow_pulse = meta_in_valid && full;  // strobe dropped

    ////////////////////
    // resolution

    assign head_entry = map_table[q_port[rd_ptr]];
    assign resolved   = head_entry.valid ? head_entry.egr_spec : default_egr;

    assign meta_avail         = (count != '0);
    assign meta_head.ing_port = q_port[rd_ptr];
    assign meta_head.egr_spec = q_frozen[rd_ptr] ? q_spec[rd_ptr] : resolved;

    ////////////////////
    // queue control

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            q_frozen <= '0;
        end else begin
            if (push) begin
                wr_ptr           <= ptr_inc(wr_ptr);
                q_frozen[wr_ptr] <= 1'b0;           // fresh entry follows the map
            end
            if (first_beat)
                q_frozen[rd_ptr] <= 1'b1;           // lock spec for this packet
            if (pkt_done)
                rd_ptr <= ptr_inc(rd_ptr);
            count <= count + CNT_W'(push) - CNT_W'(pkt_done);
        end
    end

    // payload, no reset
    always_ff @(posedge clk) begin
        if (push)
            q_port[wr_ptr] <= meta_in_port;
        if (first_beat)
            q_spec[rd_ptr] <= resolved;
    end

    // stream side only finishes a packet it had metadata for
    assert property (@(posedge clk) disable iff (!rst_n) pkt_done |-> count != '0);

endmodule

/* design/p4_router_stream.sv */
// p4 router stream stage
// one beat register, holds packets until metadata is ready, flags packet end

module p4_router_stream (
    input  var logic                     clk,
    input  var logic                     rst_n,
    input  var p4_router_pkg::beat_t     in_beat,
    input  var logic                     in_valid,
    input  var logic                     out_ready,
    input  var logic                     meta_avail,
    input  var p4_router_pkg::meta_out_t meta_head,
    output var logic                     in_ready,
    output var p4_router_pkg::beat_t     out_beat,
    output var logic                     out_valid,
    output var p4_router_pkg::meta_out_t meta_out,
    output var logic                     meta_out_valid,
    output var logic                     pkt_done,
    output var logic                     first_beat
);

    typedef enum logic {
        PKT_START,                                  // next output beat opens a packet
        PKT_BODY                                    // inside a packet
    } pkt_state_t;

    pkt_state_t           pkt_state;
    p4_router_pkg::beat_t beat_q;                   // held beat
    logic                 beat_full;                // beat_q occupied
    logic                 in_xfer;
    logic                 out_xfer;

    ////////////////////
    // handshakes

    assign out_valid = beat_full && meta_avail;    // wait for packet metadata
    assign out_xfer  = out_valid && out_ready;
    // room when empty, or when the held beat leaves this cycle
    assign in_ready  = !beat_full || out_xfer;
    assign in_xfer   = in_valid && in_ready;
    assign out_beat  = beat_q;

    ////////////////////
    // packet tracking

    assign first_beat     = out_xfer && (pkt_state == PKT_START);
    assign pkt_done       = out_xfer && beat_q.tlast;
    assign meta_out_valid = pkt_done;
    assign meta_out       = pkt_done ? meta_head : '0;  // only meaningful on last beat

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            beat_full <= 1'b0;
            pkt_state <= PKT_START;
        end else begin
            if (in_xfer)
                beat_full <= 1'b1;
            else if (out_xfer)
                beat_full <= 1'b0;                  // drained with nothing behind
            if (out_xfer)
                pkt_state <= beat_q.tlast ? PKT_START : PKT_BODY;
        end
    end

    // payload register
    always_ff @(posedge clk) begin
        if (in_xfer)
            beat_q <= in_beat;
    end

    // stalled beat must not change or disappear
    assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_beat));

endmodule

/* design/p4_router_top.sv */
// p4 router top level
// port-map forwarding of a packet stream with register access

module p4_router_top #(
    parameter int META_DEPTH = 4
) (
    input  var logic                     clk,
    input  var logic                     rst_n,
    // input stream
    input  var p4_router_pkg::beat_t     in_beat,
    input  var logic                     in_valid,
    output var logic                     in_ready,
    input  var p4_router_pkg::ing_port_t meta_in_port,
    input  var logic                     meta_in_valid,
    // output stream
    output var p4_router_pkg::beat_t     out_beat,
    output var logic                     out_valid,
    input  var logic                     out_ready,
    output var p4_router_pkg::meta_out_t meta_out,
    output var logic                     meta_out_valid,
    // register port
    input  var logic                     reg_wr,
    input  var logic                     reg_rd,
    input  var p4_router_pkg::reg_addr_t reg_addr,
    input  var p4_router_pkg::reg_data_t reg_wdata,
    output var p4_router_pkg::reg_data_t reg_rdata,
    output var logic                     overflow_event
);

    p4_router_pkg::map_table_t map_table;          // regs to lookup
    p4_router_pkg::egr_spec_t  default_egr;
    p4_router_pkg::meta_out_t  meta_head;          // lookup to stream
    logic                      meta_avail;
    logic                      pkt_done;            // stream to lookup and regs
    logic                      first_beat;
    logic                      overflow_pulse;

    p4_router_regs regs_i (
        .clk, .rst_n, .reg_wr, .reg_rd, .reg_addr, .reg_wdata,
        .pkt_done, .overflow_pulse,
        .reg_rdata, .map_table, .default_egr, .overflow_event
    );

    p4_router_lookup #(.META_DEPTH(META_DEPTH)) lookup_i (
        .clk, .rst_n, .meta_in_port, .meta_in_valid,
        .map_table, .default_egr, .pkt_done, .first_beat,
        .meta_avail, .meta_head, .overflow_pulse
    );

    p4_router_stream stream_i (
        .clk, .rst_n, .in_beat, .in_valid, .out_ready,
        .meta_avail, .meta_head,
        .in_ready, .out_beat, .out_valid, .meta_out, .meta_out_valid,
        .pkt_done, .first_beat
    );

endmodule

/* testbench/p4_router_tb.sv */
// p4 router testbench
// random and directed packet traffic checked against a port-map reference model

module p4_router_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int          TIMEOUT = 1000;             // cycles allowed per wait
    localparam logic [31:0] SEED    = 32'h028991e3;

    logic                     clk = 1'b0;
    logic                     rst_n;
    p4_router_pkg::beat_t     in_beat;
    logic                     in_valid;
    logic                     in_ready;
    p4_router_pkg::ing_port_t meta_in_port;
    logic                     meta_in_valid;
    p4_router_pkg::beat_t     out_beat;
    logic                     out_valid;
    logic                     out_ready;
    p4_router_pkg::meta_out_t meta_out;
    logic                     meta_out_valid;
    logic                     reg_wr;
    logic                     reg_rd;
    p4_router_pkg::reg_addr_t reg_addr;
    p4_router_pkg::reg_data_t reg_wdata;
    p4_router_pkg::reg_data_t reg_rdata;
    logic                     overflow_event;

    ////////////////////
    // reference state

    logic                     map_valid [p4_router_pkg::MAP_ENTRIES];
    p4_router_pkg::egr_spec_t map_spec [p4_router_pkg::MAP_ENTRIES];
    p4_router_pkg::egr_spec_t def_egr;
    p4_router_pkg::beat_t     exp_beats [$];            // in send order
    p4_router_pkg::meta_out_t exp_meta [$];             // spec filled on first output beat
    p4_router_pkg::beat_t     cmp_beat;
    p4_router_pkg::meta_out_t cmp_meta;
    p4_router_pkg::reg_data_t rd_val;
    logic [31:0]              rng_main  = SEED;
    logic [31:0]              rng_stall = ~SEED;        // own stream for out_ready
    logic                     stall_en  = 1'b0;
    logic                     out_start = 1'b1;         // next output beat opens a packet
    int                       first_beats = 0;
    int                       pkts_sent   = 0;
    int                       fb_mark;
    int                       beat_errors = 0;
    int                       meta_errors = 0;
    int                       reg_errors  = 0;
    int                       flag_errors = 0;
    int                       misc_errors = 0;

    p4_router_top #(.META_DEPTH(4)) dut_i (.*);

    always #10 clk = ~clk;                              // 20 ns period

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] rand_word();
        rng_main = lcg_next(rng_main);
        return rng_main;
    endfunction

    function automatic int rand_pick(input int n);
        rng_main = lcg_next(rng_main);
        return int'(rng_main[31:16]) % n;               // high bits, better period
    endfunction

    // expected egress for a port, valid entry first, else the default
    function automatic p4_router_pkg::egr_spec_t ref_egress(input p4_router_pkg::ing_port_t p);
        return map_valid[p] ? map_spec[p] : def_egr;
    endfunction

    function automatic p4_router_pkg::reg_data_t map_word(input logic v,
                                                          input p4_router_pkg::egr_spec_t s);
        p4_router_pkg::reg_data_t w;
        w = '0;
        w[p4_router_pkg::MAP_VALID_BIT]  = v;
        w[p4_router_pkg::EGR_SPEC_W-1:0] = s;
        return w;
    endfunction

    ////////////////////
    // compare tasks

    task automatic check_beat(input string name, input p4_router_pkg::beat_t got,
                              input p4_router_pkg::beat_t exp);
        if (got !== exp) begin
            $display("Error: %s got %h expected %h", name, got, exp);
            beat_errors++;
        end
    endtask

    task automatic check_meta(input string name, input p4_router_pkg::meta_out_t got,
                              input p4_router_pkg::meta_out_t exp);
        if (got !== exp) begin
            $display("Error: %s got %h expected %h", name, got, exp);
            meta_errors++;
        end
    endtask

    task automatic check_reg(input string name, input p4_router_pkg::reg_data_t got,
                             input p4_router_pkg::reg_data_t exp);
        if (got !== exp) begin
            $display("Error: %s got %h expected %h", name, got, exp);
            reg_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error: %s got %h expected %h", name, got, exp);
            flag_errors++;
        end
    endtask

    task automatic report_and_finish();
        $display("errors beat %0d meta %0d reg %0d flag %0d other %0d",
                 beat_errors, meta_errors, reg_errors, flag_errors, misc_errors);
        if (beat_errors + meta_errors + reg_errors + flag_errors + misc_errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    endtask

    task automatic timed_out(input string what);
        $display("timed out waiting for %s", what);
        misc_errors++;
        report_and_finish();
    endtask

    ////////////////////
    // drivers, entered and left just after a falling edge

    task automatic reg_write(input p4_router_pkg::reg_addr_t a, input p4_router_pkg::reg_data_t d);
        int idx;
        reg_wr    = 1'b1;
        reg_addr  = a;
        reg_wdata = d;
        @(negedge clk);
        reg_wr = 1'b0;
        idx    = int'(a) - int'(p4_router_pkg::REG_MAP_BASE);
        if (a == p4_router_pkg::REG_DEFAULT_EGR)
            def_egr = d[p4_router_pkg::EGR_SPEC_W-1:0];
        if (idx >= 0 && idx < p4_router_pkg::MAP_ENTRIES) begin
            map_valid[idx] = d[p4_router_pkg::MAP_VALID_BIT];   // model follows the edge
            map_spec[idx]  = d[p4_router_pkg::EGR_SPEC_W-1:0];
        end
    endtask

    task automatic reg_read(input p4_router_pkg::reg_addr_t a, output p4_router_pkg::reg_data_t d);
        reg_rd   = 1'b1;
        reg_addr = a;
        @(negedge clk);
        reg_rd = 1'b0;
        d      = reg_rdata;                             // registered on the edge between
    endtask

    task automatic strobe_meta(input p4_router_pkg::ing_port_t p, input logic kept);
        p4_router_pkg::meta_out_t m;
        m.ing_port    = p;
        m.egr_spec    = '0;
        meta_in_port  = p;
        meta_in_valid = 1'b1;
        if (kept)
            exp_meta.push_back(m);                      // dropped strobes are not expected
        @(negedge clk);
        meta_in_valid = 1'b0;
    endtask

    // meta_at -1 strobes before the packet, 0 or 1 with that beat, -2 never
    task automatic send_packet(input p4_router_pkg::ing_port_t p, input int len, input int meta_at);
        p4_router_pkg::beat_t     b;
        p4_router_pkg::meta_out_t m;
        int                       strobe_at;
        logic                     taken;
        int                       tries;
        strobe_at = (meta_at >= len) ? 0 : meta_at;
        if (strobe_at == -1)
            strobe_meta(p, 1'b1);
        for (int i = 0; i < len; i++) begin
            b.tdata  = {rand_word(), rand_word()};
            b.tlast  = (i == len - 1);
            b.tkeep  = b.tlast ? 8'hff >> rand_pick(8) : 8'hff;
            in_beat  = b;
            in_valid = 1'b1;
            if (i == strobe_at) begin
                m.ing_port    = p;
                m.egr_spec    = '0;
                meta_in_port  = p;
                meta_in_valid = 1'b1;                   // strobe during the packet
                exp_meta.push_back(m);
            end
            exp_beats.push_back(b);
            taken = 1'b0;
            tries = 0;
            while (!taken) begin
                @(posedge clk);
                taken = in_ready;                       // value before the edge
                @(negedge clk);
                if (i == strobe_at)
                    meta_in_valid = 1'b0;               // strobe lasts one cycle
                tries++;
                if (!taken && tries > TIMEOUT)
                    timed_out("an input beat to be accepted");
            end
            in_valid = 1'b0;
            if (stall_en && rand_pick(4) == 0) begin
                @(posedge clk);                         // idle gap
                @(negedge clk);
            end
        end
        pkts_sent++;
    endtask

    task automatic wait_idle();
        int tries;
        tries = 0;
        while (exp_beats.size() != 0 || exp_meta.size() != 0) begin
            @(negedge clk);
            tries++;
            if (tries > TIMEOUT)
                timed_out("the output to drain");
        end
    endtask

    task automatic wait_first_beat(input int prev);
        int tries;
        tries = 0;
        while (first_beats <= prev) begin
            @(negedge clk);
            tries++;
            if (tries > TIMEOUT)
                timed_out("the first output beat of a packet");
        end
    endtask

    always @(negedge clk) begin
        rng_stall = lcg_next(rng_stall);
        out_ready = stall_en ? (rng_stall[31:30] != 2'b00) : 1'b1;  // about 1 in 4 stalls
    end

    ////////////////////
    // output compare

    always @(posedge clk) begin
        if (rst_n) begin
            if (out_valid && out_ready) begin
                if (exp_beats.size() == 0) begin
                    $display("output beat transferred with none expected");
                    misc_errors++;
                end else begin
                    cmp_beat = exp_beats.pop_front();
                    check_beat("out_beat", out_beat, cmp_beat);
                end
                if (out_start) begin
                    first_beats++;
                    if (exp_meta.size() == 0) begin
                        $display("output packet started with no metadata sent");
                        misc_errors++;
                    end else begin
                        cmp_meta          = exp_meta.pop_front();
                        cmp_meta.egr_spec = ref_egress(cmp_meta.ing_port);  // frozen here
                        exp_meta.push_front(cmp_meta);
                    end
                end
                out_start = out_beat.tlast;
            end
            if (meta_out_valid) begin
                if (!(out_valid && out_ready && out_beat.tlast)) begin
                    $display("meta_out_valid high outside a last beat transfer");
                    misc_errors++;
                end
                if (exp_meta.size() == 0) begin
                    $display("metadata output with none expected");
                    misc_errors++;
                end else begin
                    check_meta("meta_out", meta_out, exp_meta.pop_front());
                end
            end else if (out_valid && out_ready && out_beat.tlast) begin
                $display("last beat transferred without meta_out_valid");
                misc_errors++;
            end
        end
    end

    ////////////////////
    // main sequence

    initial begin
        rst_n         = 1'b0;
        in_beat       = '0;
        in_valid      = 1'b0;
        meta_in_port  = '0;
        meta_in_valid = 1'b0;
        out_ready     = 1'b1;
        reg_wr        = 1'b0;
        reg_rd        = 1'b0;
        reg_addr      = '0;
        reg_wdata     = '0;
        def_egr       = '0;
        foreach (map_valid[i]) begin
            map_valid[i] = 1'b0;
            map_spec[i]  = '0;
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_flag("out_valid", out_valid, 1'b0);
        check_flag("in_ready", in_ready, 1'b1);
        check_flag("meta_out_valid", meta_out_valid, 1'b0);
        check_flag("overflow_event", overflow_event, 1'b0);

        // even ports mapped, odd ports fall back to the default
        reg_write(p4_router_pkg::REG_DEFAULT_EGR, 32'h0000_000a);
        for (int i = 0; i < p4_router_pkg::MAP_ENTRIES; i++)
            reg_write(p4_router_pkg::REG_MAP_BASE + p4_router_pkg::reg_addr_t'(i),
                      map_word(i % 2 == 0, p4_router_pkg::egr_spec_t'(i ^ 5)));
        reg_read(p4_router_pkg::REG_DEFAULT_EGR, rd_val);
        check_reg("default_egr", rd_val, p4_router_pkg::reg_data_t'(def_egr));
        for (int i = 0; i < p4_router_pkg::MAP_ENTRIES; i++) begin
            reg_read(p4_router_pkg::REG_MAP_BASE + p4_router_pkg::reg_addr_t'(i), rd_val);
            check_reg("map_table", rd_val, map_word(map_valid[i], map_spec[i]));
        end

        stall_en = 1'b1;
        repeat (40)
            send_packet(p4_router_pkg::ing_port_t'(rand_pick(16)), 1 + rand_pick(6),
                        rand_pick(3) - 1);
        wait_idle();

        // map rewrite lands while a 6 beat packet is in flight
        stall_en = 1'b0;
        reg_write(p4_router_pkg::REG_MAP_BASE + 6'd2, map_word(1'b1, 4'h6));
        fb_mark = first_beats;
        fork
            send_packet(4'd2, 6, -1);
            begin
                wait_first_beat(fb_mark);
                reg_write(p4_router_pkg::REG_MAP_BASE + 6'd2, map_word(1'b1, 4'h9));
            end
        join
        send_packet(4'd2, 2, -1);                       // sees the new spec
        wait_idle();

        // strobe held back, output must stay quiet
        fork
            send_packet(4'd7, 4, -2);
            begin
                repeat (8) begin
                    @(posedge clk);
                    if (out_valid) begin
                        $display("output beat appeared before its metadata");
                        misc_errors++;
                    end
                end
                @(negedge clk);
                strobe_meta(4'd7, 1'b1);
            end
        join
        wait_idle();

        for (int i = 1; i <= 5; i++)
            strobe_meta(p4_router_pkg::ing_port_t'(i), i <= 4);  // fifth overflows
        reg_read(p4_router_pkg::REG_STATUS, rd_val);
        check_reg("status", rd_val, 32'h1);
        check_flag("overflow_event", overflow_event, 1'b1);
        reg_write(p4_router_pkg::REG_STATUS, 32'h1);
        reg_read(p4_router_pkg::REG_STATUS, rd_val);
        check_reg("status", rd_val, 32'h0);
        check_flag("overflow_event", overflow_event, 1'b0);
        stall_en = 1'b1;
        repeat (4)
            send_packet(p4_router_pkg::ing_port_t'(rand_pick(16)), 1 + rand_pick(6), -2);
        wait_idle();

        reg_read(p4_router_pkg::REG_PKT_COUNT, rd_val);
        check_reg("pkt_count", rd_val, p4_router_pkg::reg_data_t'(pkts_sent));
        report_and_finish();
    end

endmodule

/* build.f */
design/p4_router_pkg.sv
design/p4_router_regs.sv
design/p4_router_lookup.sv
design/p4_router_stream.sv
design/p4_router_top.sv
testbench/p4_router_tb.sv
